// ==== io_host_config.svh ====
// ******************************
// IO host address map
// ******************************

`ifndef IO_HOST_CONFIG_SVH
`define IO_HOST_CONFIG_SVH

// Command channel widths
`define HOST_ADDR_WIDTH 20

`define HOST_DATA_WIDTH 64

// Enables for icache, dcache, lce, cce, dram, vm, cmt,
// core profile, pc profile, branch profile and cosim
`define HOST_TRACE_COUNT 11

// Register addresses, both on 8-byte boundaries
`define HOST_TRACE_ADDR 20'h00100

`define HOST_FINISH_ADDR 20'h00108

// Word memory window
`define HOST_MEM_BASE 20'h80000

`define HOST_MEM_WORDS 256

`define HOST_MEM_IDX_WIDTH 8

`endif

// ==== io_host_pkg.sv ====
// ******************************
// IO host types
// ******************************

package io_host_pkg;

  // Memory command opcode
  typedef enum logic
  {
    HOST_LOAD  = 1'b0,
    HOST_STORE = 1'b1
  } host_opcode_e;

  // Target of a decoded command
  typedef enum logic [1:0]
  {
    REGION_TRACE  = 2'd0,
    REGION_FINISH = 2'd1,
    REGION_MEM    = 2'd2,
    REGION_NONE   = 2'd3
  } host_region_e;

endpackage

// ==== io_host_decoder.sv ====
// ******************************
// IO host command decoder
// ******************************

`include "io_host_config.svh"

module io_host_decoder
  import io_host_pkg::*;
(
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  input  logic                        cmd_v_i,
  output logic                        cmd_ready_o,
  input  host_opcode_e                cmd_opcode_i,
  input  logic [`HOST_ADDR_WIDTH-1:0] cmd_addr_i,
  input  logic [`HOST_DATA_WIDTH-1:0] cmd_data_i,
  input  logic                        dec_ready_i,
  output logic                        dec_v_o,
  output host_opcode_e                dec_opcode_o,
  output host_region_e                dec_region_o,
  output logic [`HOST_ADDR_WIDTH-1:0] dec_addr_o,
  output logic [`HOST_DATA_WIDTH-1:0] dec_data_o,
  output logic                        reg_we_o,
  output logic                        mem_we_o
);

  // First byte past the memory window
  localparam logic [`HOST_ADDR_WIDTH-1:0] mem_end_lp =
    `HOST_MEM_BASE + `HOST_MEM_WORDS * 8;

  logic                        v_r;
  host_opcode_e                opcode_r;
  host_region_e                region_r;
  logic [`HOST_ADDR_WIDTH-1:0] addr_r;
  logic [`HOST_DATA_WIDTH-1:0] data_r;
  host_region_e                region_n;
  logic                        capture;
  logic                        advance;
  logic                        is_store;

  // Region lookup on the incoming address
  always_comb
  begin
    if (cmd_addr_i[2:0] != 3'b000)
      region_n = REGION_NONE;
    else if (cmd_addr_i == `HOST_TRACE_ADDR)
      region_n = REGION_TRACE;
    else if (cmd_addr_i == `HOST_FINISH_ADDR)
      region_n = REGION_FINISH;
    else if (cmd_addr_i >= `HOST_MEM_BASE && cmd_addr_i < mem_end_lp)
      region_n = REGION_MEM;
    else
      region_n = REGION_NONE;
  end

  assign advance     = v_r & dec_ready_i;
  assign cmd_ready_o = ~v_r | dec_ready_i;
  assign capture     = cmd_v_i & cmd_ready_o;

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      v_r <= 1'b0;
    else if (capture)
      v_r <= 1'b1;
    else if (advance)
      v_r <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (capture)
    begin
      opcode_r <= cmd_opcode_i;
      region_r <= region_n;
      addr_r   <= cmd_addr_i;
      data_r   <= cmd_data_i;
    end
  end

  assign is_store = (opcode_r == HOST_STORE);

  // Strobes fire only on the advance cycle
  assign reg_we_o = advance & is_store
                    & ((region_r == REGION_TRACE) | (region_r == REGION_FINISH));
  assign mem_we_o = advance & is_store & (region_r == REGION_MEM);

  assign dec_v_o      = v_r;
  assign dec_opcode_o = opcode_r;
  assign dec_region_o = region_r;
  assign dec_addr_o   = addr_r;
  assign dec_data_o   = data_r;

  // A stalled command stays put until the response stage takes it
  a_hold_stable: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    (v_r && !dec_ready_i) |=> (v_r && $stable(opcode_r) && $stable(region_r)
                               && $stable(addr_r) && $stable(data_r))
  );

endmodule

// ==== io_host_trace_regs.sv ====
// ******************************
// Trace and finish registers
// ******************************

`include "io_host_config.svh"

module io_host_trace_regs
(
  input  logic                         clk_i,
  input  logic                         arst_n_i,
  input  logic                         reg_we_i,
  input  logic [`HOST_ADDR_WIDTH-1:0]  addr_i,
  input  logic [`HOST_DATA_WIDTH-1:0]  wdata_i,
  output logic [`HOST_DATA_WIDTH-1:0]  rdata_o,
  output logic [`HOST_TRACE_COUNT-1:0] trace_en_o,
  output logic                         finish_o
);

  logic [`HOST_TRACE_COUNT-1:0] trace_en_r;
  logic                         finish_r;
  logic                         sel_trace;
  logic                         sel_finish;

  assign sel_trace  = (addr_i == `HOST_TRACE_ADDR);
  assign sel_finish = (addr_i == `HOST_FINISH_ADDR);

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      trace_en_r <= '0;
    else if (reg_we_i && sel_trace)
      trace_en_r <= wdata_i[`HOST_TRACE_COUNT-1:0];
  end

  // Sticky, only reset clears it
  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      finish_r <= 1'b0;
    else if (reg_we_i && sel_finish && wdata_i[0])
      finish_r <= 1'b1;
  end

  // Read mux, unselected addresses read as zero
  always_comb
  begin
    rdata_o = '0;
    if (sel_trace)
      rdata_o[`HOST_TRACE_COUNT-1:0] = trace_en_r;
    else if (sel_finish)
      rdata_o[0] = finish_r;
  end

  assign trace_en_o = trace_en_r;
  assign finish_o   = finish_r;

  a_finish_sticky: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    finish_r |=> finish_r
  );

endmodule

// ==== io_host_word_mem.sv ====
// ******************************
// IO host word memory
// ******************************

`include "io_host_config.svh"

module io_host_word_mem
(
  input  logic                        clk_i,
  input  logic                        mem_we_i,
  input  logic [`HOST_ADDR_WIDTH-1:0] addr_i,
  input  logic [`HOST_DATA_WIDTH-1:0] wdata_i,
  output logic [`HOST_DATA_WIDTH-1:0] rdata_o
);

  logic [`HOST_DATA_WIDTH-1:0]   mem [`HOST_MEM_WORDS];
  logic [`HOST_MEM_IDX_WIDTH-1:0] idx;

  // Word index sits just above the byte offset
  assign idx = addr_i[`HOST_MEM_IDX_WIDTH+2:3];

  always_ff @(posedge clk_i)
  begin
    if (mem_we_i)
      mem[idx] <= wdata_i;
  end

  // Asynchronous read port
  assign rdata_o = mem[idx];

endmodule

// ==== io_host_resp_buffer.sv ====
// ******************************
// IO host response buffer
// ******************************

`include "io_host_config.svh"

module io_host_resp_buffer
  import io_host_pkg::*;
(
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  input  logic                        dec_v_i,
  output logic                        dec_ready_o,
  input  host_opcode_e                dec_opcode_i,
  input  host_region_e                dec_region_i,
  input  logic [`HOST_DATA_WIDTH-1:0] reg_rdata_i,
  input  logic [`HOST_DATA_WIDTH-1:0] mem_rdata_i,
  output logic                        resp_v_o,
  input  logic                        resp_ready_i,
  output host_opcode_e                resp_opcode_o,
  output logic [`HOST_DATA_WIDTH-1:0] resp_data_o,
  output logic                        resp_err_o
);

  logic                        v_r;
  host_opcode_e                opcode_r;
  logic [`HOST_DATA_WIDTH-1:0] data_r;
  logic                        err_r;
  logic [`HOST_DATA_WIDTH-1:0] data_n;
  logic                        advance;

  assign dec_ready_o = ~v_r | resp_ready_i;
  assign advance     = dec_v_i & dec_ready_o;

  // Only loads to a mapped region carry data
  always_comb
  begin
    data_n = '0;
    if (dec_opcode_i == HOST_LOAD)
    begin
      unique case (dec_region_i)
        REGION_TRACE, REGION_FINISH: data_n = reg_rdata_i;
        REGION_MEM:                  data_n = mem_rdata_i;
        default:                     data_n = '0;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      v_r <= 1'b0;
    else if (advance)
      v_r <= 1'b1;
    else if (resp_ready_i)
      v_r <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (advance)
    begin
      opcode_r <= dec_opcode_i;
      data_r   <= data_n;
      err_r    <= (dec_region_i == REGION_NONE);
    end
  end

  assign resp_v_o      = v_r;
  assign resp_opcode_o = opcode_r;
  assign resp_data_o   = data_r;
  assign resp_err_o    = err_r;

  a_resp_hold: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    (v_r && !resp_ready_i) |=> (v_r && $stable(data_r) && $stable(err_r)
                                && $stable(opcode_r))
  );

endmodule

// ==== io_host_top.sv ====
// ******************************
// IO host top level
// ******************************

`include "io_host_config.svh"

module io_host_top
  import io_host_pkg::*;
(
  input  logic                         clk_i,
  input  logic                         arst_n_i,
  input  logic                         cmd_v_i,
  output logic                         cmd_ready_o,
  input  host_opcode_e                 cmd_opcode_i,
  input  logic [`HOST_ADDR_WIDTH-1:0]  cmd_addr_i,
  input  logic [`HOST_DATA_WIDTH-1:0]  cmd_data_i,
  output logic                         resp_v_o,
  input  logic                         resp_ready_i,
  output host_opcode_e                 resp_opcode_o,
  output logic [`HOST_DATA_WIDTH-1:0]  resp_data_o,
  output logic                         resp_err_o,
  output logic [`HOST_TRACE_COUNT-1:0] trace_en_o,
  output logic                         finish_o
);

  // Decoder to response buffer
  logic                        dec_v;
  logic                        dec_ready;
  host_opcode_e                dec_opcode;
  host_region_e                dec_region;
  logic [`HOST_ADDR_WIDTH-1:0] dec_addr;
  logic [`HOST_DATA_WIDTH-1:0] dec_data;

  // Write strobes and read data
  logic                        reg_we;
  logic                        mem_we;
  logic [`HOST_DATA_WIDTH-1:0] reg_rdata;
  logic [`HOST_DATA_WIDTH-1:0] mem_rdata;

  io_host_decoder io_host_decoder_inst
  (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .cmd_v_i      (cmd_v_i),
    .cmd_ready_o  (cmd_ready_o),
    .cmd_opcode_i (cmd_opcode_i),
    .cmd_addr_i   (cmd_addr_i),
    .cmd_data_i   (cmd_data_i),
    .dec_ready_i  (dec_ready),
    .dec_v_o      (dec_v),
    .dec_opcode_o (dec_opcode),
    .dec_region_o (dec_region),
    .dec_addr_o   (dec_addr),
    .dec_data_o   (dec_data),
    .reg_we_o     (reg_we),
    .mem_we_o     (mem_we)
  );

  io_host_trace_regs io_host_trace_regs_inst
  (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .reg_we_i   (reg_we),
    .addr_i     (dec_addr),
    .wdata_i    (dec_data),
    .rdata_o    (reg_rdata),
    .trace_en_o (trace_en_o),
    .finish_o   (finish_o)
  );

  io_host_word_mem io_host_word_mem_inst
  (
    .clk_i    (clk_i),
    .mem_we_i (mem_we),
    .addr_i   (dec_addr),
    .wdata_i  (dec_data),
    .rdata_o  (mem_rdata)
  );

  io_host_resp_buffer io_host_resp_buffer_inst
  (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .dec_v_i       (dec_v),
    .dec_ready_o   (dec_ready),
    .dec_opcode_i  (dec_opcode),
    .dec_region_i  (dec_region),
    .reg_rdata_i   (reg_rdata),
    .mem_rdata_i   (mem_rdata),
    .resp_v_o      (resp_v_o),
    .resp_ready_i  (resp_ready_i),
    .resp_opcode_o (resp_opcode_o),
    .resp_data_o   (resp_data_o),
    .resp_err_o    (resp_err_o)
  );

endmodule

// ==== tb_io_host.sv ====
// ******************************
// IO host testbench
// ******************************

`include "io_host_config.svh"

module tb_io_host
  import io_host_pkg::*;
();

  // Tests take a few hundred cycles in total
  localparam int unsigned TIMEOUT_CYCLES = 4000;
  localparam logic [`HOST_ADDR_WIDTH-1:0] MEM_END = `HOST_MEM_BASE + `HOST_MEM_WORDS * 8;

  logic                         clk_i;
  logic                         arst_n_i;
  logic                         cmd_v_i;
  logic                         cmd_ready_o;
  host_opcode_e                 cmd_opcode_i;
  logic [`HOST_ADDR_WIDTH-1:0]  cmd_addr_i;
  logic [`HOST_DATA_WIDTH-1:0]  cmd_data_i;
  logic                         resp_v_o;
  logic                         resp_ready_i;
  host_opcode_e                 resp_opcode_o;
  logic [`HOST_DATA_WIDTH-1:0]  resp_data_o;
  logic                         resp_err_o;
  logic [`HOST_TRACE_COUNT-1:0] trace_en_o;
  logic                         finish_o;

  integer      seed;
  int unsigned cycle_cnt = 0;
  bit          lat_check;
  bit          bp_mode;
  bit          bp_now;
  bit          saw_stall;

  // Expected responses, oldest first
  logic [`HOST_DATA_WIDTH-1:0] exp_data_q [$];
  bit                          exp_err_q [$];
  bit                          exp_known_q [$];
  host_opcode_e                exp_op_q [$];
  int unsigned                 exp_cyc_q [$];

  // Reference state
  logic [`HOST_DATA_WIDTH-1:0]  mem_model [`HOST_MEM_WORDS];
  bit                           mem_valid [`HOST_MEM_WORDS];
  logic [`HOST_TRACE_COUNT-1:0] trace_model;
  bit                           finish_model;

  io_host_top io_host_top_inst
  (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .cmd_v_i       (cmd_v_i),
    .cmd_ready_o   (cmd_ready_o),
    .cmd_opcode_i  (cmd_opcode_i),
    .cmd_addr_i    (cmd_addr_i),
    .cmd_data_i    (cmd_data_i),
    .resp_v_o      (resp_v_o),
    .resp_ready_i  (resp_ready_i),
    .resp_opcode_o (resp_opcode_o),
    .resp_data_o   (resp_data_o),
    .resp_err_o    (resp_err_o),
    .trace_en_o    (trace_en_o),
    .finish_o      (finish_o)
  );

  initial
    clk_i = 1'b0;

  always #10 clk_i = ~clk_i;

  task automatic abort_run();
    $display("Simulation finished: FAIL");
    $fatal(1, "Run stopped at cycle %0d", cycle_cnt);
  endtask

  task automatic compare_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
    assert (got === exp)
    else
    begin
      $display("MISMATCH %s: got 0x%h expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  always @(posedge clk_i)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES)
    begin
      $display("Timeout after %0d cycles, %0d responses still pending",
               cycle_cnt, exp_data_q.size());
      abort_run();
    end
  end

  // Random response back-pressure when enabled
  always @(posedge clk_i)
  begin
    bp_now = bp_mode;
    #1;
    if (bp_now)
      resp_ready_i = $random(seed);
    else
      resp_ready_i = 1'b1;
  end

  // Expected response from the address map and result rules
  task automatic model_cmd(input host_opcode_e op, input logic [19:0] addr,
                           input logic [63:0] data, output logic [63:0] ed,
                           output bit ee, output bit ek);
    int unsigned idx;
    bit          is_mem;
    idx    = (addr - `HOST_MEM_BASE) >> 3;
    is_mem = (addr >= `HOST_MEM_BASE) && (addr < MEM_END);
    ed = '0;
    ee = 1'b0;
    ek = 1'b1;
    if (addr[2:0] != 3'b000)
      ee = 1'b1;
    else if (addr == `HOST_TRACE_ADDR)
    begin
      if (op == HOST_STORE)
        trace_model = data[`HOST_TRACE_COUNT-1:0];
      else
        ed[`HOST_TRACE_COUNT-1:0] = trace_model;
    end
    else if (addr == `HOST_FINISH_ADDR)
    begin
      if (op == HOST_STORE && data[0])
        finish_model = 1'b1;
      else if (op == HOST_LOAD)
        ed[0] = finish_model;
    end
    else if (is_mem)
    begin
      if (op == HOST_STORE)
      begin
        mem_model[idx] = data;
        mem_valid[idx] = 1'b1;
      end
      else
      begin
        ed = mem_model[idx];
        ek = mem_valid[idx];
      end
    end
    else
      ee = 1'b1;
  endtask

  // Called a step after a rising edge, returns a step after the handshake edge
  task automatic send_cmd(input host_opcode_e op, input logic [19:0] addr,
                          input logic [63:0] data);
    bit          taken;
    int unsigned acc_cyc;
    logic [63:0] ed;
    bit          ee;
    bit          ek;
    cmd_v_i      = 1'b1;
    cmd_opcode_i = op;
    cmd_addr_i   = addr;
    cmd_data_i   = data;
    taken        = 1'b0;
    while (!taken)
    begin
      @(negedge clk_i);
      taken   = cmd_ready_o;
      acc_cyc = cycle_cnt;
      @(posedge clk_i);
      #1;
    end
    cmd_v_i = 1'b0;
    model_cmd(op, addr, data, ed, ee, ek);
    exp_data_q.push_back(ed);
    exp_err_q.push_back(ee);
    exp_known_q.push_back(ek);
    exp_op_q.push_back(op);
    exp_cyc_q.push_back(acc_cyc);
  endtask

  task automatic check_resp();
    logic [63:0]  ed;
    bit           ee;
    bit           ek;
    host_opcode_e eo;
    int unsigned  ec;
    assert (exp_data_q.size() != 0)
    else
    begin
      $display("A response arrived with no command pending");
      abort_run();
    end
    ed = exp_data_q.pop_front();
    ee = exp_err_q.pop_front();
    ek = exp_known_q.pop_front();
    eo = exp_op_q.pop_front();
    ec = exp_cyc_q.pop_front();
    compare_value("resp_opcode_o", resp_opcode_o, eo);
    compare_value("resp_err_o", resp_err_o, ee);
    if (ek)
      compare_value("resp_data_o", resp_data_o, ed);
    if (lat_check)
    begin
      assert (cycle_cnt - ec == 2)
      else
      begin
        $display("Response came %0d cycles after its command instead of 2",
                 cycle_cnt - ec);
        abort_run();
      end
    end
  endtask

  // Handshakes complete at the following rising edge
  always @(negedge clk_i)
  begin
    if (arst_n_i)
    begin
      if (!cmd_ready_o)
      begin
        saw_stall = saw_stall | cmd_v_i;
        assert (exp_data_q.size() == 2)
        else
        begin
          $display("cmd_ready_o is low with %0d commands pending instead of 2",
                   exp_data_q.size());
          abort_run();
        end
      end
      if (resp_v_o && resp_ready_i)
        check_resp();
    end
  end

  task automatic drain();
    do
      @(posedge clk_i);
    while (exp_data_q.size() != 0);
    #1;
  endtask

  task automatic test_reset();
    compare_value("cmd_ready_o", cmd_ready_o, 1'b1);
    compare_value("resp_v_o", resp_v_o, 1'b0);
    compare_value("finish_o", finish_o, 1'b0);
    compare_value("trace_en_o", trace_en_o, '0);
  endtask

  task automatic test_mem_round_trip();
    logic [19:0] addrs [32];
    logic [63:0] data;
    logic [7:0]  idx;
    lat_check = 1'b1;
    for (int i = 0; i < 32; i++)
    begin
      idx          = $random(seed);
      data[63:32]  = $random(seed);
      data[31:0]   = $random(seed);
      addrs[i]     = `HOST_MEM_BASE + {idx, 3'b000};
      send_cmd(HOST_STORE, addrs[i], data);
    end
    for (int i = 0; i < 32; i++)
      send_cmd(HOST_LOAD, addrs[i], 64'h0);
    drain();
    lat_check = 1'b0;
  endtask

  task automatic test_trace_enables();
    logic [63:0] data;
    for (int i = 0; i < 3; i++)
    begin
      data[63:32] = $random(seed);
      data[31:0]  = $random(seed);
      send_cmd(HOST_STORE, `HOST_TRACE_ADDR, data);
      // Enables update at the advance edge
      @(posedge clk_i);
      #1;
      compare_value("trace_en_o", trace_en_o, trace_model);
      send_cmd(HOST_LOAD, `HOST_TRACE_ADDR, 64'h0);
    end
    drain();
  endtask

  task automatic test_finish();
    logic [63:0] pattern [3];
    pattern[0] = 64'h0;
    pattern[1] = 64'h1;
    pattern[2] = 64'hffff_ffff_ffff_fffe;
    for (int i = 0; i < 3; i++)
    begin
      send_cmd(HOST_STORE, `HOST_FINISH_ADDR, pattern[i]);
      @(posedge clk_i);
      #1;
      compare_value("finish_o", finish_o, finish_model);
    end
    send_cmd(HOST_LOAD, `HOST_FINISH_ADDR, 64'h0);
    drain();
  endtask

  task automatic test_errors();
    logic [19:0] word5;
    word5 = `HOST_MEM_BASE + 20'h28;
    send_cmd(HOST_STORE, word5, 64'h0123_4567_89ab_cdef);
    send_cmd(HOST_STORE, 20'h00200, 64'hdead_beef_dead_beef);
    send_cmd(HOST_LOAD, 20'h00200, 64'h0);
    send_cmd(HOST_STORE, `HOST_TRACE_ADDR + 20'h4, '1);
    send_cmd(HOST_STORE, MEM_END, '1);
    send_cmd(HOST_STORE, word5 + 20'h2, '1);
    send_cmd(HOST_LOAD, word5 + 20'h7, 64'h0);
    send_cmd(HOST_LOAD, word5, 64'h0);
    send_cmd(HOST_LOAD, `HOST_TRACE_ADDR, 64'h0);
    drain();
    compare_value("trace_en_o", trace_en_o, trace_model);
  endtask

  task automatic test_backpressure();
    host_opcode_e ops [24];
    logic [19:0]  addrs [24];
    logic [63:0]  datas [24];
    for (int i = 0; i < 24; i++)
    begin
      ops[i]          = (i < 8 || $random(seed) % 2) ? HOST_STORE : HOST_LOAD;
      addrs[i]        = `HOST_MEM_BASE + ((i < 8) ? i * 8 : ($random(seed) & 7) * 8);
      datas[i][63:32] = $random(seed);
      datas[i][31:0]  = $random(seed);
    end
    saw_stall = 1'b0;
    bp_mode   = 1'b1;
    for (int i = 0; i < 24; i++)
      send_cmd(ops[i], addrs[i], datas[i]);
    drain();
    bp_mode = 1'b0;
    assert (saw_stall)
    else
    begin
      $display("cmd_ready_o never dropped under back-pressure");
      abort_run();
    end
  endtask

  initial
  begin
    seed         = 32'h8e80_8383;
    arst_n_i     = 1'b0;
    cmd_v_i      = 1'b0;
    cmd_opcode_i = HOST_LOAD;
    cmd_addr_i   = '0;
    cmd_data_i   = '0;
    resp_ready_i = 1'b1;
    bp_mode      = 1'b0;
    lat_check    = 1'b0;
    saw_stall    = 1'b0;
    trace_model  = '0;
    finish_model = 1'b0;
    repeat (5) @(posedge clk_i);
    #1;
    arst_n_i = 1'b1;
    test_reset();
    test_mem_round_trip();
    test_trace_enables();
    test_finish();
    test_errors();
    test_backpressure();
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

// ==== project.f ====
+incdir+.
io_host_pkg.sv
io_host_decoder.sv
io_host_trace_regs.sv
io_host_word_mem.sv
io_host_resp_buffer.sv
io_host_top.sv
tb_io_host.sv

// ==== Bender.yml ====
package:
  name: io_host

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - io_host_pkg.sv
      - io_host_decoder.sv
      - io_host_trace_regs.sv
      - io_host_word_mem.sv
      - io_host_resp_buffer.sv
      - io_host_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_io_host.sv
